// ==== verilog/lmx_pkg.sv ====
package lmx_pkg;

  typedef logic [31:0] lmx_word_t;  // one synthesizer program or readback word
  typedef logic [1:0]  reg_idx_t;   // wb_adr_i[3:2]

  localparam reg_idx_t REG_DATA = 2'd0;
  localparam reg_idx_t REG_CTRL = 2'd1;
  localparam reg_idx_t REG_STAT = 2'd2;  // index 3 unused

  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_START,  // waiting for first serial fall
    SEQ_SHIFT,
    SEQ_LAST,   // all 32 rises seen
    SEQ_LATCH
  } seq_state_t;

  typedef struct packed {
    logic load;       // holding word into shifter
    logic shift_out;  // next output bit
    logic sample_in;  // muxout into capture
  } spi_step_t;

endpackage

// ==== verilog/lmx_wb_regs.sv ====
`timescale 1ns/1ps

module lmx_wb_regs import lmx_pkg::*; (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic [31:0] wb_adr_i,
  input  logic [31:0] wb_dat_i,
  input  logic [3:0]  wb_sel_i,
  input  logic        wb_we_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        busy_i,
  input  logic        done_i,
  input  lmx_word_t   capture_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o,
  output logic        wb_err_o,
  output logic        start_o,
  output lmx_word_t   word_o,
  output logic        ce_o,
  output logic        be_o
);

  logic      ack_q;
  logic      err_q;
  logic      start_q;
  logic      ce_q;
  logic      be_q;
  lmx_word_t hold_q;
  lmx_word_t readback_q;
  lmx_word_t rdata_q;
  lmx_word_t rd_mux;
  reg_idx_t  idx;
  logic      req;
  logic      data_wr;
  logic      reject;

  assign idx     = wb_adr_i[3:2];
  assign req     = wb_cyc_i && wb_stb_i && !ack_q && !err_q;  // one answer per request
  assign data_wr = req && wb_we_i && (idx == REG_DATA);
  assign reject  = data_wr && busy_i;  // no queue, transfer in flight

  always_comb begin
    case (idx)
      REG_DATA: rd_mux = readback_q;
      REG_CTRL: rd_mux = {30'd0, be_q, ce_q};
      REG_STAT: rd_mux = {31'd0, busy_i};
      default:  rd_mux = '0;
    endcase
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_q   <= 1'b0;
      err_q   <= 1'b0;
      start_q <= 1'b0;
      ce_q    <= 1'b0;
      be_q    <= 1'b0;
    end else begin
      ack_q   <= req && !reject;
      err_q   <= reject;
      start_q <= data_wr && !busy_i;  // lands in the ack cycle
      if (req && wb_we_i && (idx == REG_CTRL) && wb_sel_i[0]) begin
        ce_q <= wb_dat_i[0];
        be_q <= wb_dat_i[1];
      end
    end
  end

  // byte merge into the holding word
  always_ff @(posedge wb_clk_i) begin
    if (data_wr && !busy_i) begin
      for (int i = 0; i < 4; i++) begin
        if (wb_sel_i[i]) begin
          hold_q[8*i +: 8] <= wb_dat_i[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (done_i) begin
      readback_q <= capture_i;
    end
    if (req) begin
      rdata_q <= wb_we_i ? '0 : rd_mux;  // writes return zero
    end
  end

  assign wb_dat_o = wb_ack_o ? rdata_q : '0;
  assign wb_ack_o = ack_q;
  assign wb_err_o = err_q;
  assign start_o  = start_q;
  assign word_o   = hold_q;
  assign ce_o     = ce_q;
  assign be_o     = be_q;

  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i) !(wb_ack_o && wb_err_o))
    else $error("wb_ack_o and wb_err_o high together");

endmodule

// ==== verilog/lmx_sclk_gen.sv ====
`timescale 1ns/1ps

module lmx_sclk_gen #(
  parameter int SPI_CLK_DIV_BITS = 5
) (
  input  logic wb_clk_i,
  input  logic restart_i,
  output logic sclk_o,
  output logic rise_o,
  output logic fall_o
);

  logic [SPI_CLK_DIV_BITS-1:0] cnt_q = '0;
  logic                        sclk_q = 1'b0;  // previous serial clock level

  always_ff @(posedge wb_clk_i) begin
    if (restart_i) begin
      cnt_q  <= '0;  // known phase per transfer
      sclk_q <= 1'b0;
    end else begin
      cnt_q  <= cnt_q + 1'b1;
      sclk_q <= sclk_o;
    end
  end

  assign sclk_o = cnt_q[SPI_CLK_DIV_BITS-1];  // high in second half of period
  assign rise_o = sclk_o && !sclk_q;
  assign fall_o = !sclk_o && sclk_q;

  assert property (@(posedge wb_clk_i) !(rise_o && fall_o))
    else $error("rise_o and fall_o in the same cycle");

endmodule

// ==== verilog/lmx_spi_sequencer.sv ====
`timescale 1ns/1ps

module lmx_spi_sequencer import lmx_pkg::*; (
  input  logic      wb_clk_i,
  input  logic      wb_rst_i,
  input  logic      start_i,
  input  logic      rise_i,
  input  logic      fall_i,
  output spi_step_t step_o,
  output logic      clk_en_o,
  output logic      le_o,
  output logic      busy_o,
  output logic      done_o
);

  seq_state_t state_q;
  logic [4:0] bit_cnt_q;
  logic       clk_en_q;
  logic       le_q;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state_q   <= SEQ_IDLE;
      bit_cnt_q <= '0;
      clk_en_q  <= 1'b0;
      le_q      <= 1'b0;
    end else if (start_i) begin
      state_q   <= SEQ_START;  // restarts from any state
      bit_cnt_q <= '0;
      clk_en_q  <= 1'b0;
      le_q      <= 1'b0;
    end else begin
      case (state_q)
        SEQ_START: begin
          if (fall_i) begin
            state_q   <= SEQ_SHIFT;
            clk_en_q  <= 1'b1;
            bit_cnt_q <= '0;
          end
        end
        SEQ_SHIFT: begin
          if (rise_i) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 5'd31) begin
              state_q <= SEQ_LAST;
            end
          end
        end
        SEQ_LAST: begin
          if (fall_i) begin
            clk_en_q <= 1'b0;  // pin clock stays low from here
            le_q     <= 1'b1;
            state_q  <= SEQ_LATCH;
          end
        end
        SEQ_LATCH: begin
          if (rise_i) begin
            le_q    <= 1'b0;
            state_q <= SEQ_IDLE;
          end
        end
        default: begin
          state_q <= SEQ_IDLE;
        end
      endcase
    end
  end

  assign step_o.load      = (state_q == SEQ_START) && fall_i;
  assign step_o.shift_out = (state_q == SEQ_SHIFT) && fall_i;
  assign step_o.sample_in = (state_q == SEQ_SHIFT) && rise_i;

  assign clk_en_o = clk_en_q;
  assign le_o     = le_q;
  assign busy_o   = start_i || (state_q != SEQ_IDLE);
  assign done_o   = (state_q == SEQ_LATCH) && rise_i;  // capture is final here

  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i) !(le_o && clk_en_o))
    else $error("latch enable while pin clock enabled");

endmodule

// ==== verilog/lmx_spi_shifter.sv ====
`timescale 1ns/1ps

module lmx_spi_shifter import lmx_pkg::*; (
  input  logic      wb_clk_i,
  input  spi_step_t step_i,
  input  lmx_word_t word_i,
  input  logic      muxout_i,
  output logic      sdo_o,
  output lmx_word_t capture_o
);

  lmx_word_t out_q;
  lmx_word_t cap_q;

  // msb first towards the synthesizer
  always_ff @(posedge wb_clk_i) begin
    if (step_i.load) begin
      out_q <= word_i;
    end else if (step_i.shift_out) begin
      out_q <= {out_q[30:0], 1'b0};
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (step_i.load) begin
      cap_q <= '0;
    end else if (step_i.sample_in) begin
      cap_q <= {cap_q[30:0], muxout_i};  // fills from the right
    end
  end

  assign sdo_o     = out_q[31];
  assign capture_o = cap_q;

endmodule

// ==== verilog/lmx2581_ctrl_top.sv ====
`timescale 1ns/1ps

module lmx2581_ctrl_top import lmx_pkg::*; #(
  parameter int SPI_CLK_DIV_BITS = 5
) (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_err_o,
  output logic        wb_ack_o,
  input  logic [31:0] wb_adr_i,
  input  logic [3:0]  wb_sel_i,
  input  logic [31:0] wb_dat_i,
  input  logic        wb_we_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        lmx_muxout_i,
  output logic        lmx_clk_o,
  output logic        lmx_data_o,
  output logic        lmx_le_o,
  output logic        lmx_ce_o,
  output logic        lmx_be_o
);

  logic      start;
  logic      busy;
  logic      done;
  logic      sclk;
  logic      sclk_rise;
  logic      sclk_fall;
  logic      clk_en;
  lmx_word_t hold_word;
  lmx_word_t capture;
  spi_step_t step;

  lmx_wb_regs lmx_wb_regs_inst (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .wb_adr_i  (wb_adr_i),
    .wb_dat_i  (wb_dat_i),
    .wb_sel_i  (wb_sel_i),
    .wb_we_i   (wb_we_i),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .busy_i    (busy),
    .done_i    (done),
    .capture_i (capture),
    .wb_dat_o  (wb_dat_o),
    .wb_ack_o  (wb_ack_o),
    .wb_err_o  (wb_err_o),
    .start_o   (start),
    .word_o    (hold_word),
    .ce_o      (lmx_ce_o),
    .be_o      (lmx_be_o)
  );

  lmx_sclk_gen #(
    .SPI_CLK_DIV_BITS (SPI_CLK_DIV_BITS)
  ) lmx_sclk_gen_inst (
    .wb_clk_i  (wb_clk_i),
    .restart_i (start),
    .sclk_o    (sclk),
    .rise_o    (sclk_rise),
    .fall_o    (sclk_fall)
  );

  lmx_spi_sequencer lmx_spi_sequencer_inst (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .start_i  (start),
    .rise_i   (sclk_rise),
    .fall_i   (sclk_fall),
    .step_o   (step),
    .clk_en_o (clk_en),
    .le_o     (lmx_le_o),
    .busy_o   (busy),
    .done_o   (done)
  );

  lmx_spi_shifter lmx_spi_shifter_inst (
    .wb_clk_i  (wb_clk_i),
    .step_i    (step),
    .word_i    (hold_word),
    .muxout_i  (lmx_muxout_i),
    .sdo_o     (lmx_data_o),
    .capture_o (capture)
  );

  assign lmx_clk_o = sclk && clk_en;  // clock only inside a transfer

endmodule

// ==== verif/lmx_tb_checks.sv ====
`timescale 1ns/1ps

module lmx_tb_checks import lmx_pkg::*; (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic        cyc_i,
  input  logic        stb_i,
  input  logic        ack_i,
  input  logic        err_i,
  input  logic [31:0] rdata_i,
  input  logic        lmx_clk_i,
  input  logic        lmx_le_i,
  input  logic        lmx_ce_i,
  input  logic        lmx_be_i,
  input  logic        rd_check_i,
  input  lmx_word_t   exp_rdata_i,
  input  logic        exp_err_i,
  input  logic        exp_ce_i,
  input  logic        exp_be_i,
  input  logic        tx_pending_i,
  input  lmx_word_t   exp_tx_i,
  input  lmx_word_t   rx_word_i,
  input  int          rx_count_i,
  output int          bus_errs_o,
  output int          spi_errs_o
);

  int   bus_errs = 0;
  int   spi_errs = 0;
  logic req;
  logic le_q;
  int   le_pulses;  // latch pulses since the transfer began

  assign req        = cyc_i && stb_i && !ack_i && !err_i;  // new request, not yet answered
  assign bus_errs_o = bus_errs;
  assign spi_errs_o = spi_errs;

  always_ff @(posedge wb_clk_i) begin
    le_q <= lmx_le_i;
    if (!tx_pending_i) begin
      le_pulses <= 0;
    end else if (lmx_le_i && !le_q) begin
      le_pulses <= le_pulses + 1;
    end
  end

  assert property (@(posedge wb_clk_i)
    $fell(wb_rst_i) |-> !(lmx_clk_i || lmx_le_i || lmx_ce_i || lmx_be_i || ack_i || err_i))
    else begin
      $display("outputs were not all low when reset was released");
      bus_errs++;
    end

  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i) req |=> (ack_i != err_i))
    else begin
      $display("request did not get exactly one of ack and err one cycle later");
      bus_errs++;
    end

  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i) !req |=> !(ack_i || err_i))
    else begin
      $display("ack or err seen without a pending request");
      bus_errs++;
    end

  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i) !ack_i |-> rdata_i == '0)
    else begin
      $display("Fail wb_dat_o: got %h expected %h", $sampled(rdata_i), 32'h0);
      bus_errs++;
    end

  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    ack_i && rd_check_i |-> rdata_i == exp_rdata_i)
    else begin
      $display("Fail wb_dat_o: got %h expected %h", $sampled(rdata_i), $sampled(exp_rdata_i));
      bus_errs++;
    end

  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (ack_i || err_i) |-> err_i == exp_err_i)
    else begin
      $display("Fail wb_err_o: got %h expected %h", $sampled(err_i), $sampled(exp_err_i));
      bus_errs++;
    end

  // pins may move during the request cycle itself
  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    !(cyc_i && stb_i) |-> lmx_ce_i == exp_ce_i)
    else begin
      $display("Fail lmx_ce_o: got %h expected %h", $sampled(lmx_ce_i), $sampled(exp_ce_i));
      bus_errs++;
    end

  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    !(cyc_i && stb_i) |-> lmx_be_i == exp_be_i)
    else begin
      $display("Fail lmx_be_o: got %h expected %h", $sampled(lmx_be_i), $sampled(exp_be_i));
      bus_errs++;
    end

  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i) lmx_le_i |-> !lmx_clk_i)
    else begin
      $display("lmx_le_o was high while lmx_clk_o was high");
      spi_errs++;
    end

  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (lmx_clk_i || lmx_le_i) |-> tx_pending_i)
    else begin
      $display("serial clock or latch enable moved with no transfer started");
      spi_errs++;
    end

  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    $fell(tx_pending_i) |-> le_pulses == 1)
    else begin
      $display("Fail lmx_le_o pulses: got %h expected %h", $sampled(le_pulses), 1);
      spi_errs++;
    end

  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    $rose(lmx_le_i) |-> rx_count_i == 32)
    else begin
      $display("Fail lmx_clk_o rises: got %h expected %h", $sampled(rx_count_i), 32);
      spi_errs++;
    end

  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    $rose(lmx_le_i) |-> rx_word_i == exp_tx_i)
    else begin
      $display("Fail lmx_data_o word: got %h expected %h",
               $sampled(rx_word_i), $sampled(exp_tx_i));
      spi_errs++;
    end

endmodule

// ==== verif/tb_lmx2581_ctrl.sv ====
`timescale 1ns/1ps

module tb_lmx2581_ctrl import lmx_pkg::*; ();

  localparam int DIV_BITS   = 3;
  localparam int BUS_LIMIT  = 8;    // cycles to wait for ack or err
  localparam int POLL_LIMIT = 400;  // status reads before giving up

  logic        wb_clk_i;
  logic        wb_rst_i;
  logic [31:0] wb_adr_i;
  logic [31:0] wb_dat_i;
  logic [3:0]  wb_sel_i;
  logic        wb_we_i;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        lmx_muxout_i;
  logic [31:0] wb_dat_o;
  logic        wb_ack_o;
  logic        wb_err_o;
  logic        lmx_clk_o;
  logic        lmx_data_o;
  logic        lmx_le_o;
  logic        lmx_ce_o;
  logic        lmx_be_o;

  // expected values for the checker
  logic      rd_check;
  lmx_word_t exp_rdata;
  logic      exp_err;
  logic      exp_ce;
  logic      exp_be;
  logic      tx_pending;
  lmx_word_t exp_hold;
  lmx_word_t exp_tx;

  // synthesizer model state
  lmx_word_t rx_shift = '0;
  lmx_word_t rx_word  = '0;
  lmx_word_t rb_word  = '0;
  int        rx_bits  = 0;
  int        rx_count = 0;
  int        rb_idx   = 0;

  int n_reads  = 0;
  int n_writes = 0;
  int n_tx     = 0;
  int bus_errs;
  int spi_errs;

  lmx2581_ctrl_top #(
    .SPI_CLK_DIV_BITS (DIV_BITS)
  ) lmx2581_ctrl_top_inst (
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .wb_dat_o     (wb_dat_o),
    .wb_err_o     (wb_err_o),
    .wb_ack_o     (wb_ack_o),
    .wb_adr_i     (wb_adr_i),
    .wb_sel_i     (wb_sel_i),
    .wb_dat_i     (wb_dat_i),
    .wb_we_i      (wb_we_i),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .lmx_muxout_i (lmx_muxout_i),
    .lmx_clk_o    (lmx_clk_o),
    .lmx_data_o   (lmx_data_o),
    .lmx_le_o     (lmx_le_o),
    .lmx_ce_o     (lmx_ce_o),
    .lmx_be_o     (lmx_be_o)
  );

  lmx_tb_checks lmx_tb_checks_inst (
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .cyc_i        (wb_cyc_i),
    .stb_i        (wb_stb_i),
    .ack_i        (wb_ack_o),
    .err_i        (wb_err_o),
    .rdata_i      (wb_dat_o),
    .lmx_clk_i    (lmx_clk_o),
    .lmx_le_i     (lmx_le_o),
    .lmx_ce_i     (lmx_ce_o),
    .lmx_be_i     (lmx_be_o),
    .rd_check_i   (rd_check),
    .exp_rdata_i  (exp_rdata),
    .exp_err_i    (exp_err),
    .exp_ce_i     (exp_ce),
    .exp_be_i     (exp_be),
    .tx_pending_i (tx_pending),
    .exp_tx_i     (exp_tx),
    .rx_word_i    (rx_word),
    .rx_count_i   (rx_count),
    .bus_errs_o   (bus_errs),
    .spi_errs_o   (spi_errs)
  );

  always #5 wb_clk_i = ~wb_clk_i;

  // synthesizer takes data on rises, latches the word on le
  always @(posedge lmx_clk_o or posedge lmx_le_o) begin
    if (lmx_le_o) begin
      rx_word  <= rx_shift;
      rx_count <= rx_bits;
      rx_bits  <= 0;
    end else begin
      rx_shift <= {rx_shift[30:0], lmx_data_o};
      rx_bits  <= rx_bits + 1;
    end
  end

  always @(negedge lmx_clk_o or posedge lmx_le_o) begin
    if (lmx_le_o) begin
      rb_idx <= 0;
    end else if (tx_pending) begin
      rb_idx <= rb_idx + 1;  // next readback bit after each fall
    end
  end

  always @(negedge wb_clk_i) begin
    lmx_muxout_i <= (rb_idx < 32) ? rb_word[31 - rb_idx] : 1'b0;
  end

  task automatic print_counts();
    $display("reads %0d, writes %0d, transfers %0d, bus errors %0d, serial errors %0d",
             n_reads, n_writes, n_tx, bus_errs, spi_errs);
  endtask

  task automatic abort_run(input string what);
    $display("Timeout while %s", what);
    print_counts();
    $display("Something failed");
    $finish;
  endtask

  task automatic finish_run();
    print_counts();
    if (bus_errs == 0 && spi_errs == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  endtask

  // one Wishbone access, called on a falling edge
  task automatic bus_access(input logic we, input reg_idx_t idx, input lmx_word_t data,
                            input logic [3:0] sel, output lmx_word_t rdata);
    int waited;
    waited   = 0;
    wb_adr_i = {28'd0, idx, 2'b00};
    wb_dat_i = data;
    wb_sel_i = sel;
    wb_we_i  = we;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    @(negedge wb_clk_i);
    while (!(wb_ack_o || wb_err_o)) begin
      if (waited == BUS_LIMIT) begin
        abort_run("waiting for ack or err");
      end
      waited++;
      @(negedge wb_clk_i);
    end
    rdata    = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    if (we) begin
      n_writes++;
    end else begin
      n_reads++;
    end
    @(negedge wb_clk_i);
    rd_check = 1'b0;
    exp_err  = 1'b0;
  endtask

  task automatic check_read(input reg_idx_t idx, input lmx_word_t expected);
    lmx_word_t rd;
    exp_rdata = expected;
    rd_check  = 1'b1;
    bus_access(1'b0, idx, 32'h0, 4'hf, rd);
  endtask

  task automatic wait_idle();
    lmx_word_t st;
    int        polls;
    polls = 0;
    bus_access(1'b0, REG_STAT, 32'h0, 4'hf, st);
    while (st[0]) begin
      if (polls == POLL_LIMIT) begin
        abort_run("waiting for busy to fall");
      end
      polls++;
      bus_access(1'b0, REG_STAT, 32'h0, 4'hf, st);
    end
  endtask

  task automatic run_transfer(input lmx_word_t data, input logic [3:0] sel,
                              input logic try_reject);
    lmx_word_t rd;
    rb_word = $urandom();
    for (int i = 0; i < 4; i++) begin
      if (sel[i]) begin
        exp_hold[8*i +: 8] = data[8*i +: 8];  // unselected bytes stay
      end
    end
    exp_tx     = exp_hold;
    tx_pending = 1'b1;
    bus_access(1'b1, REG_DATA, data, sel, rd);
    check_read(REG_STAT, 32'h1);
    if (try_reject) begin
      exp_err = 1'b1;
      bus_access(1'b1, REG_DATA, $urandom(), 4'hf, rd);
    end
    wait_idle();
    tx_pending = 1'b0;
    n_tx++;
    check_read(REG_DATA, rb_word);
  endtask

  task automatic write_ctrl(input logic [1:0] bits);
    lmx_word_t rd;
    exp_ce = bits[0];
    exp_be = bits[1];
    bus_access(1'b1, REG_CTRL, {30'd0, bits}, 4'hf, rd);
    check_read(REG_CTRL, {30'd0, bits});
  endtask

  initial begin
    lmx_word_t rd;
    void'($urandom(32'h5d8c));
    wb_clk_i     = 1'b0;
    wb_rst_i     = 1'b1;
    wb_adr_i     = '0;
    wb_dat_i     = '0;
    wb_sel_i     = '0;
    wb_we_i      = 1'b0;
    wb_cyc_i     = 1'b0;
    wb_stb_i     = 1'b0;
    lmx_muxout_i = 1'b0;
    rd_check     = 1'b0;
    exp_rdata    = '0;
    exp_err      = 1'b0;
    exp_ce       = 1'b0;
    exp_be       = 1'b0;
    tx_pending   = 1'b0;
    exp_hold     = '0;
    exp_tx       = '0;
    repeat (5) @(negedge wb_clk_i);
    wb_rst_i = 1'b0;
    @(negedge wb_clk_i);

    check_read(REG_STAT, 32'h0);
    check_read(REG_CTRL, 32'h0);

    run_transfer($urandom(), 4'hf, 1'b0);  // full word first, holding word starts unknown
    run_transfer($urandom(), 4'hf, 1'b0);
    run_transfer($urandom(), 4'b0101, 1'b0);
    run_transfer($urandom(), 4'hf, 1'b1);
    run_transfer($urandom(), 4'b1000, 1'b0);

    write_ctrl(2'b01);
    write_ctrl(2'b10);
    write_ctrl(2'b11);
    write_ctrl(2'b00);

    // unused index, no transfer may follow
    bus_access(1'b1, 2'd3, $urandom(), 4'hf, rd);
    check_read(2'd3, 32'h0);
    repeat (4 << DIV_BITS) @(negedge wb_clk_i);
    check_read(REG_STAT, 32'h0);

    finish_run();
  end

endmodule

// ==== tb.f ====
verilog/lmx_pkg.sv
verilog/lmx_wb_regs.sv
verilog/lmx_sclk_gen.sv
verilog/lmx_spi_sequencer.sv
verilog/lmx_spi_shifter.sv
verilog/lmx2581_ctrl_top.sv
verif/lmx_tb_checks.sv
verif/tb_lmx2581_ctrl.sv

// ==== Bender.yml ====
package:
  name: lmx2581_ctrl

sources:
  - files:
      - verilog/lmx_pkg.sv
      - verilog/lmx_wb_regs.sv
      - verilog/lmx_sclk_gen.sv
      - verilog/lmx_spi_sequencer.sv
      - verilog/lmx_spi_shifter.sv
      - verilog/lmx2581_ctrl_top.sv
  - target: simulation
    files:
      - verif/lmx_tb_checks.sv
      - verif/tb_lmx2581_ctrl.sv
